// ==== cpu.f ====
+incdir+source
source/wires.sv
source/fetch_stage.sv
source/decoder.sv
source/register.sv
source/alu.sv
source/execute_stage.sv
source/cpu.sv
dv/cpu_tb.sv

// ==== dv/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tb;

  localparam int PROG_LEN = 200;
  localparam int LAST = PROG_LEN - 1;
  localparam int MEM_WORDS = 256;
  localparam logic [31:0] END_PC = `RESET_VECTOR + 32'(LAST * 4);
  localparam realtime TIMEOUT = (PROG_LEN * 8 + 16 + 50) * 100.0;
  localparam int K_LUI = 0;
  localparam int K_ADDI = 1;
  localparam int K_REG = 2;
  localparam int K_LW = 3;
  localparam int K_SW = 4;
  localparam int K_BEQ = 5;
  localparam int K_BNE = 6;
  localparam int K_JAL = 7;

  logic clock;
  logic rst;
  logic [31:0] imem_rdata;
  logic dmem_ack;
  logic [31:0] dmem_rdata;
  logic [31:0] imem_addr;
  logic dmem_req;
  logic dmem_we;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;

  logic [31:0] lfsr;
  logic [31:0] rom [PROG_LEN];
  int kind [PROG_LEN];
  int op_sel [PROG_LEN];
  logic [4:0] rd_f [PROG_LEN];
  logic [4:0] rs1_f [PROG_LEN];
  logic [4:0] rs2_f [PROG_LEN];
  logic [31:0] imm_f [PROG_LEN];
  logic [31:0] dmem [MEM_WORDS];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int stores_seen;
  int stores_expected;
  logic [31:0] addr_seen;
  logic prev_req;
  logic prev_ack;
  logic prev_we;
  logic [31:0] prev_addr;
  logic [31:0] prev_wdata;
  logic waiting;
  logic [1:0] delay;

  cpu UUT (.*);

  function automatic logic lfsr_step();
    logic out;
    out = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ 32'h8020_0003;
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) v = {v[30:0], lfsr_step()};
    return v;
  endfunction

  // reference results of the register operations, in funct order of the generator
  function automatic logic [31:0] model_alu(input int op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      0: return a + b;
      1: return a - b;
      2: return a & b;
      3: return a | b;
      4: return a ^ b;
      5: return {31'b0, $signed(a) < $signed(b)};
      6: return a << b[4:0];
      default: return a >> b[4:0];
    endcase
  endfunction

  function automatic logic [31:0] encode(input int i);
    logic [31:0] m;
    logic [2:0] f3 [8];
    f3 = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b010, 3'b001, 3'b101};
    m = imm_f[i];
    case (kind[i])
      K_LUI: return {m[31:12], rd_f[i], `OP_LUI};
      K_ADDI: return {m[11:0], rs1_f[i], 3'b000, rd_f[i], `OP_IMM};
      K_REG: return {(op_sel[i] == 1) ? 7'h20 : 7'h00, rs2_f[i], rs1_f[i], f3[op_sel[i]],
                     rd_f[i], `OP_REG};
      K_LW: return {m[11:0], 5'd0, 3'b010, rd_f[i], `OP_LOAD};
      K_SW: return {m[11:5], rs2_f[i], 5'd0, 3'b010, m[4:0], `OP_STORE};
      K_BEQ, K_BNE: return {m[12], m[10:5], rs2_f[i], rs1_f[i],
                            (kind[i] == K_BNE) ? 3'b001 : 3'b000, m[4:1], m[11], `OP_BRANCH};
      default: return {m[20], m[10:1], m[11], m[19:12], rd_f[i], `OP_JAL};
    endcase
  endfunction

  task automatic generate_program();
    int i;
    int k;
    i = 0;
    while (i < LAST) begin
      kind[i] = int'(rand_bits(3));
      op_sel[i] = int'(rand_bits(3));
      rd_f[i] = 5'(rand_bits(3));
      rs1_f[i] = 5'(rand_bits(3));
      rs2_f[i] = 5'(rand_bits(3));
      imm_f[i] = rand_bits(20);
      k = 1 + int'(rand_bits(3));
      if (i + k > LAST) k = LAST - i;
      // the first instructions give x1 to x7 known values
      if (i < 7) begin
        kind[i] = K_ADDI;
        rd_f[i] = 5'(i + 1);
        rs1_f[i] = 5'd0;
      end else if (kind[i] == K_LW && i == LAST - 1) begin
        kind[i] = K_SW;
      end
      case (kind[i])
        K_LUI: imm_f[i] = {imm_f[i][19:0], 12'b0};
        K_ADDI: imm_f[i] = {{20{imm_f[i][11]}}, imm_f[i][11:0]};
        K_LW, K_SW: imm_f[i] = {22'b0, rand_bits(8), 2'b00};
        K_BEQ, K_BNE, K_JAL: imm_f[i] = 32'(k * 4);
        default: ;
      endcase
      if (kind[i] == K_LW) begin
        // the loaded value goes back out through a store so it gets checked
        kind[i + 1] = K_SW;
        rs2_f[i + 1] = rd_f[i];
        imm_f[i + 1] = {22'b0, rand_bits(8), 2'b00};
        i++;
      end
      i++;
    end
    kind[LAST] = K_JAL;
    rd_f[LAST] = 5'd0;
    imm_f[LAST] = '0;
    for (int n = 0; n < PROG_LEN; n++) rom[n] = encode(n);
  endtask

  task automatic run_model();
    logic [31:0] r [32];
    logic [31:0] dm [MEM_WORDS];
    logic [31:0] res;
    int p;
    int next;
    r = '{default: '0};
    for (int n = 0; n < MEM_WORDS; n++) dm[n] = dmem[n];
    p = 0;
    while (p != LAST) begin
      next = p + 1;
      res = '0;
      case (kind[p])
        K_LUI: res = imm_f[p];
        K_ADDI: res = r[rs1_f[p]] + imm_f[p];
        K_REG: res = model_alu(op_sel[p], r[rs1_f[p]], r[rs2_f[p]]);
        K_LW: res = dm[imm_f[p][9:2]];
        K_SW: begin
          dm[imm_f[p][9:2]] = r[rs2_f[p]];
          exp_addr.push_back(imm_f[p]);
          exp_data.push_back(r[rs2_f[p]]);
        end
        K_BEQ: if (r[rs1_f[p]] == r[rs2_f[p]]) next = p + int'(imm_f[p] >> 2);
        K_BNE: if (r[rs1_f[p]] != r[rs2_f[p]]) next = p + int'(imm_f[p] >> 2);
        default: begin
          res = `RESET_VECTOR + 32'(p * 4 + 4);
          next = p + int'(imm_f[p] >> 2);
        end
      endcase
      if (kind[p] inside {K_LUI, K_ADDI, K_REG, K_LW, K_JAL} && rd_f[p] != 5'd0) begin
        r[rd_f[p]] = res;
      end
      p = next;
    end
  endtask

  task automatic report_error(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // instruction ROM with a one-cycle registered read
  always @(negedge clock) addr_seen = imem_addr;

  always @(posedge clock) begin
    #5;
    if (addr_seen >= `RESET_VECTOR && addr_seen <= END_PC) begin
      imem_rdata = rom[(addr_seen - `RESET_VECTOR) >> 2];
    end else begin
      imem_rdata = 32'h0000_0013;
    end
  end

  // data memory, four-phase handshake with a random ack delay
  always @(posedge clock) begin
    #5;
    if (rst) begin
      dmem_ack = 1'b0;
      waiting = 1'b0;
    end else if (!dmem_ack && dmem_req) begin
      if (!waiting) begin
        delay = 2'(rand_bits(2));
        waiting = 1'b1;
      end
      if (delay == 2'd0) begin
        assert (dmem_addr < 32'(MEM_WORDS * 4))
          else report_error($sformatf("data address %h out of range", dmem_addr));
        if (dmem_we) begin
          assert (exp_addr.size() > 0)
            else report_error("store issued beyond the end of the expected list");
          assert (dmem_addr == exp_addr[0] && dmem_wdata == exp_data[0])
            else report_error($sformatf("store %0d got %h <- %h, expected %h <- %h",
                              stores_seen, dmem_addr, dmem_wdata, exp_addr[0], exp_data[0]));
          void'(exp_addr.pop_front());
          void'(exp_data.pop_front());
          dmem[dmem_addr[9:2]] = dmem_wdata;
          stores_seen++;
        end else begin
          dmem_rdata = dmem[dmem_addr[9:2]];
        end
        dmem_ack = 1'b1;
        waiting = 1'b0;
      end else begin
        delay = delay - 2'd1;
      end
    end else if (dmem_ack && !dmem_req) begin
      dmem_ack = 1'b0;
    end
  end

  always @(negedge clock) begin
    if (!rst) begin
      if (prev_req && !prev_ack) begin
        assert (dmem_req && dmem_we == prev_we && dmem_addr == prev_addr &&
                dmem_wdata == prev_wdata)
          else report_error("request changed before ack");
      end
      // the core samples ack at the edge after it rises and lets go of req there
      if (prev_req && prev_ack) begin
        assert (!dmem_req) else report_error("request still high after ack was seen");
      end
    end
    prev_req = dmem_req;
    prev_ack = dmem_ack;
    prev_we = dmem_we;
    prev_addr = dmem_addr;
    prev_wdata = dmem_wdata;
  end

  initial begin
    #(TIMEOUT);
    $display("timeout: the program did not reach its final loop");
    $display("SOME TESTS FAILED");
    $fatal(1);
  end

  initial begin
    rst = 1'b1;
    imem_rdata = 32'h0000_0013;
    dmem_ack = 1'b0;
    dmem_rdata = '0;
    addr_seen = `RESET_VECTOR;
    prev_req = 1'b0;
    prev_ack = 1'b0;
    prev_we = 1'b0;
    prev_addr = '0;
    prev_wdata = '0;
    waiting = 1'b0;
    delay = '0;
    stores_seen = 0;
    lfsr = 32'h332c;
    generate_program();
    for (int n = 0; n < MEM_WORDS; n++) dmem[n] = rand_bits(32);
    run_model();
    stores_expected = exp_addr.size();
    repeat (16) @(posedge clock);
    #5;
    assert (imem_addr == `RESET_VECTOR && !dmem_req)
      else report_error($sformatf("reset state wrong, imem_addr %h", imem_addr));
    rst = 1'b0;
    @(negedge clock);
    while (!(stores_seen == stores_expected && imem_addr == END_PC)) @(negedge clock);
    repeat (50) begin
      @(negedge clock);
      assert (!dmem_req) else report_error("data request after the final loop");
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f cpu.f -o cpu_sim \
  || { echo "build failed"; exit 1; }
output=$(./obj_dir/cpu_sim 2>&1)
echo "$output"
echo "$output" | grep -q "ALL TESTS PASSED" && echo "simulation ok" && exit 0 \
  || { echo "simulation failed"; exit 1; }

// ==== source/alu.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module alu (
  input  wires::alu_op_type  op,
  input  logic [`XLEN-1:0]   a,
  input  logic [`XLEN-1:0]   b,
  output logic [`XLEN-1:0]   result
);

  always_comb begin
    case (op)
      wires::ALU_ADD: result = a + b;
      wires::ALU_SUB: result = a - b;
      wires::ALU_AND: result = a & b;
      wires::ALU_OR: result = a | b;
      wires::ALU_XOR: result = a ^ b;
      wires::ALU_SLT: result = `XLEN'($signed(a) < $signed(b));
      // shift amount is the low five bits of b
      wires::ALU_SLL: result = a << b[4:0];
      wires::ALU_SRL: result = a >> b[4:0];
      wires::ALU_PASS_B: result = b;
      default: result = '0;
    endcase
  end

endmodule

// ==== source/cpu.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu (
  input  logic              clock,
  input  logic              rst,
  input  logic [31:0]       imem_rdata,
  input  logic              dmem_ack,
  input  logic [`XLEN-1:0]  dmem_rdata,
  output logic [`XLEN-1:0]  imem_addr,
  output logic              dmem_req,
  output logic              dmem_we,
  output logic [`XLEN-1:0]  dmem_addr,
  output logic [`XLEN-1:0]  dmem_wdata
);

  logic [`XLEN-1:0] pc_f;
  logic valid_f;
  logic [$clog2(`REG_COUNT)-1:0] rd1_index;
  logic [$clog2(`REG_COUNT)-1:0] rd2_index;
  logic [`XLEN-1:0] rd1_data;
  logic [`XLEN-1:0] rd2_data;
  logic valid_d;
  logic [`XLEN-1:0] pc_d;
  wires::inst_class_type class_d;
  wires::alu_op_type op_d;
  logic [$clog2(`REG_COUNT)-1:0] rd_d;
  logic [`XLEN-1:0] rs1_value_d;
  logic [`XLEN-1:0] rs2_value_d;
  logic [`XLEN-1:0] imm_d;
  logic use_imm_d;
  logic branch_ne_d;
  wires::alu_op_type alu_op;
  logic [`XLEN-1:0] alu_a;
  logic [`XLEN-1:0] alu_b;
  logic [`XLEN-1:0] alu_result;
  logic stall;
  logic redirect;
  logic [`XLEN-1:0] redirect_pc;
  logic clear;
  logic wr_en;
  logic [$clog2(`REG_COUNT)-1:0] wr_index;
  logic [`XLEN-1:0] wr_data;

  // stage ports carry the same names as the nets here
  fetch_stage fetch_stage_comp (.*);

  decoder decoder_comp (.*);

  register register_comp (.*);

  execute_stage execute_stage_comp (.*);

  alu alu_comp (
    .op    (alu_op),
    .a     (alu_a),
    .b     (alu_b),
    .result(alu_result)
  );

endmodule

// ==== source/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data and address width
`define XLEN 32

// integer register count, x0 included
`define REG_COUNT 32

`define RESET_VECTOR 32'h0000_0000

// major opcodes of the supported RV32I subset
`define OP_LUI    7'b0110111
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111

`endif

// ==== source/decoder.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decoder (
  input  logic                            clock,
  input  logic                            rst,
  input  logic                            stall,
  input  logic                            clear,
  input  logic [31:0]                     imem_rdata,
  input  logic [`XLEN-1:0]                pc_f,
  input  logic                            valid_f,
  input  logic [`XLEN-1:0]                rd1_data,
  input  logic [`XLEN-1:0]                rd2_data,
  input  logic                            wr_en,
  input  logic [$clog2(`REG_COUNT)-1:0]   wr_index,
  input  logic [`XLEN-1:0]                wr_data,
  output logic [$clog2(`REG_COUNT)-1:0]   rd1_index,
  output logic [$clog2(`REG_COUNT)-1:0]   rd2_index,
  output logic                            valid_d,
  output logic [`XLEN-1:0]                pc_d,
  output wires::inst_class_type           class_d,
  output wires::alu_op_type               op_d,
  output logic [$clog2(`REG_COUNT)-1:0]   rd_d,
  output logic [`XLEN-1:0]                rs1_value_d,
  output logic [`XLEN-1:0]                rs2_value_d,
  output logic [`XLEN-1:0]                imm_d,
  output logic                            use_imm_d,
  output logic                            branch_ne_d
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;
  wires::inst_class_type class_n;
  wires::alu_op_type op_n;
  logic [`XLEN-1:0] imm_n;
  logic use_imm_n;
  logic [$clog2(`REG_COUNT)-1:0] rd_n;
  logic [`XLEN-1:0] rs1_value_n;
  logic [`XLEN-1:0] rs2_value_n;

  assign opcode = imem_rdata[6:0];
  assign funct3 = imem_rdata[14:12];
  assign funct7 = imem_rdata[31:25];
  assign rd1_index = imem_rdata[19:15];
  assign rd2_index = imem_rdata[24:20];

  assign imm_i = {{20{imem_rdata[31]}}, imem_rdata[31:20]};
  assign imm_s = {{20{imem_rdata[31]}}, imem_rdata[31:25], imem_rdata[11:7]};
  assign imm_b = {{19{imem_rdata[31]}}, imem_rdata[31], imem_rdata[7],
                  imem_rdata[30:25], imem_rdata[11:8], 1'b0};
  assign imm_u = {imem_rdata[31:12], 12'b0};
  assign imm_j = {{11{imem_rdata[31]}}, imem_rdata[31], imem_rdata[19:12],
                  imem_rdata[20], imem_rdata[30:21], 1'b0};

  // the instruction in execute writes back at the same edge this one is
  // captured, so its result bypasses the register file
  assign rs1_value_n = (wr_en && wr_index == rd1_index && rd1_index != '0) ? wr_data : rd1_data;
  assign rs2_value_n = (wr_en && wr_index == rd2_index && rd2_index != '0) ? wr_data : rd2_data;

  always_comb begin
    class_n = wires::CLASS_NONE;
    op_n = wires::ALU_ADD;
    imm_n = imm_i;
    use_imm_n = 1'b1;
    rd_n = imem_rdata[11:7];
    case (opcode)
      `OP_LUI: begin
        class_n = wires::CLASS_ALU;
        op_n = wires::ALU_PASS_B;
        imm_n = imm_u;
      end
      `OP_IMM: begin
        // ADDI is the only immediate operation kept
        if (funct3 == 3'b000) begin
          class_n = wires::CLASS_ALU;
        end
      end
      `OP_REG: begin
        class_n = wires::CLASS_ALU;
        use_imm_n = 1'b0;
        case ({funct7, funct3})
          {7'h00, 3'b000}: op_n = wires::ALU_ADD;
          {7'h20, 3'b000}: op_n = wires::ALU_SUB;
          {7'h00, 3'b111}: op_n = wires::ALU_AND;
          {7'h00, 3'b110}: op_n = wires::ALU_OR;
          {7'h00, 3'b100}: op_n = wires::ALU_XOR;
          {7'h00, 3'b010}: op_n = wires::ALU_SLT;
          {7'h00, 3'b001}: op_n = wires::ALU_SLL;
          {7'h00, 3'b101}: op_n = wires::ALU_SRL;
          default: class_n = wires::CLASS_NONE;
        endcase
      end
      `OP_LOAD: begin
        if (funct3 == 3'b010) begin
          class_n = wires::CLASS_LOAD;
        end
      end
      `OP_STORE: begin
        if (funct3 == 3'b010) begin
          class_n = wires::CLASS_STORE;
        end
        imm_n = imm_s;
        rd_n = '0;
      end
      `OP_BRANCH: begin
        // BEQ and BNE only, compared through a subtract
        if (funct3[2:1] == 2'b00) begin
          class_n = wires::CLASS_BRANCH;
        end
        op_n = wires::ALU_SUB;
        use_imm_n = 1'b0;
        imm_n = imm_b;
        rd_n = '0;
      end
      `OP_JAL: begin
        class_n = wires::CLASS_JUMP;
        imm_n = imm_j;
      end
      default: begin
        rd_n = '0;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      valid_d <= 1'b0;
    end else if (clear) begin
      valid_d <= 1'b0;
    end else if (!stall) begin
      valid_d <= valid_f;
    end
  end

  always_ff @(posedge clock) begin
    if (!stall) begin
      pc_d <= pc_f;
      class_d <= class_n;
      op_d <= op_n;
      rd_d <= rd_n;
      rs1_value_d <= rs1_value_n;
      rs2_value_d <= rs2_value_n;
      imm_d <= imm_n;
      use_imm_d <= use_imm_n;
      branch_ne_d <= funct3[0];
    end
  end

  // fetch only delivers legal instructions on the taken path
  assert property (@(posedge clock) disable iff (rst)
    valid_d |-> class_d != wires::CLASS_NONE)
    else $error("unsupported instruction reached execute at pc %h", pc_d);

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module execute_stage (
  input  logic                            clock,
  input  logic                            rst,
  input  logic                            valid_d,
  input  logic [`XLEN-1:0]                pc_d,
  input  wires::inst_class_type           class_d,
  input  wires::alu_op_type               op_d,
  input  logic [$clog2(`REG_COUNT)-1:0]   rd_d,
  input  logic [`XLEN-1:0]                rs1_value_d,
  input  logic [`XLEN-1:0]                rs2_value_d,
  input  logic [`XLEN-1:0]                imm_d,
  input  logic                            use_imm_d,
  input  logic                            branch_ne_d,
  input  logic [`XLEN-1:0]                alu_result,
  input  logic                            dmem_ack,
  input  logic [`XLEN-1:0]                dmem_rdata,
  output wires::alu_op_type               alu_op,
  output logic [`XLEN-1:0]                alu_a,
  output logic [`XLEN-1:0]                alu_b,
  output logic                            dmem_req,
  output logic                            dmem_we,
  output logic [`XLEN-1:0]                dmem_addr,
  output logic [`XLEN-1:0]                dmem_wdata,
  output logic                            stall,
  output logic                            redirect,
  output logic [`XLEN-1:0]                redirect_pc,
  output logic                            clear,
  output logic                            wr_en,
  output logic [$clog2(`REG_COUNT)-1:0]   wr_index,
  output logic [`XLEN-1:0]                wr_data
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_ACK,
    WAIT_RELEASE
  } mem_state_type;

  mem_state_type state;
  mem_state_type state_next;
  logic mem_op;
  logic mem_done;
  logic taken;

  assign alu_op = op_d;
  assign alu_a = rs1_value_d;
  assign alu_b = use_imm_d ? imm_d : rs2_value_d;

  // branches subtract the operands, so a zero result means equal
  assign taken = branch_ne_d ? (alu_result != '0) : (alu_result == '0);
  assign redirect = valid_d && (class_d == wires::CLASS_JUMP ||
                                (class_d == wires::CLASS_BRANCH && taken));
  assign redirect_pc = pc_d + imm_d;
  assign clear = redirect;

  assign mem_op = valid_d && (class_d == wires::CLASS_LOAD || class_d == wires::CLASS_STORE);
  // the operands sit in the held decode register, so address and data stay stable
  assign dmem_req = mem_op && (state == IDLE || state == WAIT_ACK);
  assign dmem_we = class_d == wires::CLASS_STORE;
  assign dmem_addr = alu_result;
  assign dmem_wdata = rs2_value_d;
  assign mem_done = dmem_req && dmem_ack;
  assign stall = mem_op && !mem_done;

  assign wr_index = rd_d;
  assign wr_en = valid_d && rd_d != '0 &&
                 (class_d == wires::CLASS_ALU || class_d == wires::CLASS_JUMP ||
                  (class_d == wires::CLASS_LOAD && mem_done));

  always_comb begin
    case (class_d)
      wires::CLASS_JUMP: wr_data = pc_d + `XLEN'(4);
      wires::CLASS_LOAD: wr_data = dmem_rdata;
      default: wr_data = alu_result;
    endcase
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (dmem_req) begin
          state_next = dmem_ack ? WAIT_RELEASE : WAIT_ACK;
        end
      end
      WAIT_ACK: begin
        if (dmem_ack) begin
          state_next = WAIT_RELEASE;
        end
      end
      WAIT_RELEASE: begin
        // a following access waits here until memory has dropped ack
        if (!dmem_ack) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  assert property (@(posedge clock) disable iff (rst)
    dmem_req |-> dmem_addr[1:0] == 2'b00)
    else $error("misaligned data access at %h", dmem_addr);

  // req rises just after an edge, so ack must have been low at that edge
  assert property (@(posedge clock) disable iff (rst)
    $rose(dmem_req) |-> !$past(dmem_ack))
    else $error("data request raised before ack was released");

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module fetch_stage (
  input  logic              clock,
  input  logic              rst,
  input  logic              stall,
  input  logic              redirect,
  input  logic [`XLEN-1:0]  redirect_pc,
  output logic [`XLEN-1:0]  imem_addr,
  output logic [`XLEN-1:0]  pc_f,
  output logic              valid_f
);

  logic [`XLEN-1:0] pc;

  // under stall the ROM is pointed back at the word decode is waiting on,
  // so that word is still on imem_rdata when the stall lifts
  assign imem_addr = stall ? pc_f : pc;

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= `RESET_VECTOR;
      pc_f <= `RESET_VECTOR;
      valid_f <= 1'b0;
    end else if (redirect) begin
      pc <= redirect_pc;
      pc_f <= pc;
      // the word already requested is on the wrong path
      valid_f <= 1'b0;
    end else if (!stall) begin
      pc <= pc + `XLEN'(4);
      pc_f <= pc;
      valid_f <= 1'b1;
    end
  end

endmodule

// ==== source/register.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module register (
  input  logic                            clock,
  input  logic                            rst,
  input  logic [$clog2(`REG_COUNT)-1:0]   rd1_index,
  input  logic [$clog2(`REG_COUNT)-1:0]   rd2_index,
  input  logic                            wr_en,
  input  logic [$clog2(`REG_COUNT)-1:0]   wr_index,
  input  logic [`XLEN-1:0]                wr_data,
  output logic [`XLEN-1:0]                rd1_data,
  output logic [`XLEN-1:0]                rd2_data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  // x0 is never written, so its read is forced to zero here
  assign rd1_data = (rd1_index == '0) ? '0 : regs[rd1_index];
  assign rd2_data = (rd2_index == '0) ? '0 : regs[rd2_index];

  always_ff @(posedge clock) begin
    if (wr_en && wr_index != '0) begin
      regs[wr_index] <= wr_data;
    end
  end

  assert property (@(posedge clock) disable iff (rst)
    wr_en |-> !$isunknown(wr_index))
    else $error("register write with unknown index");

endmodule

// ==== source/wires.sv ====
package wires;

  // operations of the integer unit
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B
  } alu_op_type;

  // what execute does with a decoded instruction
  typedef enum logic [2:0] {
    CLASS_NONE,
    CLASS_ALU,
    CLASS_LOAD,
    CLASS_STORE,
    CLASS_BRANCH,
    CLASS_JUMP
  } inst_class_type;

endpackage
